//--- rtab_top.f
rtl/rtab_pkg.sv
rtl/rtab_entry_store.sv
rtl/rtab_dep_tracker.sv
rtl/rtab_rr_arbiter.sv
rtl/rtab_pop_fsm.sv
rtl/rtab_top.sv
tb/tb_clkgen.sv
tb/tb_rtab.sv

//--- rtl/rtab_dep_tracker.sv
// Replay table dependency flags, set on allocate or rollback and cleared by refill or miss-ready
module rtab_dep_tracker #(
    parameter int N_ENTRIES = 8
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    input  logic [N_ENTRIES-1:0]    alloc_onehot_i,
    input  rtab_pkg::rtab_deps_t    alloc_deps_i,

    input  logic                    pop_rback_i,
    input  rtab_pkg::rtab_ptr_t     pop_rback_ptr_i,
    input  rtab_pkg::rtab_deps_t    pop_rback_deps_i,

    input  logic                    refill_i,
    input  logic [N_ENTRIES-1:0]    refill_match_i,
    input  logic                    miss_ready_i,

    output logic [N_ENTRIES-1:0]    nodeps_o
);

    // Miss pending on the line, and miss handler busy
    logic [N_ENTRIES-1:0] hit_q;
    logic [N_ENTRIES-1:0] busy_q;

    logic [N_ENTRIES-1:0] rback_bv;
    logic [N_ENTRIES-1:0] hit_set;
    logic [N_ENTRIES-1:0] busy_set;
    logic [N_ENTRIES-1:0] hit_clr;
    logic [N_ENTRIES-1:0] busy_clr;
    logic [N_ENTRIES-1:0] hit_alloc;
    logic [N_ENTRIES-1:0] busy_alloc;

    always_comb begin
        for (int i = 0; i < N_ENTRIES; i++) begin
            rback_bv[i] = pop_rback_i && (pop_rback_ptr_i == rtab_pkg::rtab_ptr_t'(i));
        end
    end

    // Rollback re-arms on top of whatever is still pending
    assign hit_set  = rback_bv & {N_ENTRIES{pop_rback_deps_i.mshr_hit}};
    assign busy_set = rback_bv & {N_ENTRIES{pop_rback_deps_i.mshr_ready}};

    assign hit_clr  = refill_match_i & {N_ENTRIES{refill_i}};
    assign busy_clr = {N_ENTRIES{miss_ready_i}};

    assign hit_alloc  = alloc_onehot_i & {N_ENTRIES{alloc_deps_i.mshr_hit}};
    assign busy_alloc = alloc_onehot_i & {N_ENTRIES{alloc_deps_i.mshr_ready}};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_q  <= '0;
            busy_q <= '0;
        end else begin
            // A freshly allocated slot takes its flags as given
            hit_q  <= hit_alloc
                    | (~alloc_onehot_i & ((hit_q & ~hit_clr) | hit_set));
            busy_q <= busy_alloc
                    | (~alloc_onehot_i & ((busy_q & ~busy_clr) | busy_set));
        end
    end

    assign nodeps_o = ~(hit_q | busy_q);

endmodule

//--- rtl/rtab_entry_store.sv
// Replay table entry store holding payloads, list links, free-slot choice and line matching
module rtab_entry_store #(
    parameter int N_ENTRIES = 8
) (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,

    input  logic                                     alloc_i,
    input  logic                                     alloc_link_i,
    input  rtab_pkg::rtab_req_t                      alloc_req_i,

    input  logic                                     check_i,
    input  logic [rtab_pkg::NLINE_W-1:0]             check_nline_i,
    output logic                                     check_hit_o,

    input  logic [N_ENTRIES-1:0]                     pop_take_i,
    input  logic                                     pop_commit_i,
    input  rtab_pkg::rtab_ptr_t                      pop_commit_ptr_i,
    input  logic                                     pop_rback_i,
    input  rtab_pkg::rtab_ptr_t                      pop_rback_ptr_i,

    input  logic [rtab_pkg::NLINE_W-1:0]             refill_nline_i,

    output logic [N_ENTRIES-1:0]                     head_o,
    output logic [N_ENTRIES-1:0]                     tail_o,
    output logic [N_ENTRIES-1:0]                     valid_o,
    output logic [N_ENTRIES-1:0]                     alloc_onehot_o,
    output logic [N_ENTRIES-1:0]                     refill_match_o,
    output rtab_pkg::rtab_ptr_t [N_ENTRIES-1:0]      next_ptr_o,
    output rtab_pkg::rtab_req_t [N_ENTRIES-1:0]      req_o,
    output logic                                     empty_o,
    output logic                                     full_o
);

    logic [N_ENTRIES-1:0]                valid_q;
    logic [N_ENTRIES-1:0]                head_q;
    logic [N_ENTRIES-1:0]                tail_q;
    rtab_pkg::rtab_req_t [N_ENTRIES-1:0] req_q;
    rtab_pkg::rtab_ptr_t [N_ENTRIES-1:0] next_q;

    logic [N_ENTRIES-1:0]                free;
    logic [N_ENTRIES-1:0]                free_onehot;
    logic [N_ENTRIES-1:0]                alloc_onehot;
    rtab_pkg::rtab_ptr_t                 alloc_ptr;
    logic [N_ENTRIES-1:0]                match_check;
    logic [N_ENTRIES-1:0]                link_tail;
    logic [N_ENTRIES-1:0]                commit_bv;
    logic [N_ENTRIES-1:0]                rback_bv;

    // Lowest free slot, isolated as the lowest set bit
    assign free         = ~valid_q;
    assign free_onehot  = free & (~free + 1'b1);
    assign alloc_onehot = free_onehot & {N_ENTRIES{alloc_i}};

    always_comb begin
        alloc_ptr = '0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (free_onehot[i]) begin
                alloc_ptr = rtab_pkg::rtab_ptr_t'(i);
            end
        end
    end

    // Per-entry line compares and pointer decodes
    always_comb begin
        for (int i = 0; i < N_ENTRIES; i++) begin
            match_check[i]    = valid_q[i] && (req_q[i].nline == check_nline_i);
            refill_match_o[i] = valid_q[i] && (req_q[i].nline == refill_nline_i);
            commit_bv[i]      = pop_commit_i && (pop_commit_ptr_i == rtab_pkg::rtab_ptr_t'(i));
            rback_bv[i]       = pop_rback_i && (pop_rback_ptr_i == rtab_pkg::rtab_ptr_t'(i));
        end
    end

    assign check_hit_o = check_i & (|match_check);

    // Current tail of the checked line, which the new entry is linked behind
    assign link_tail = match_check & tail_q & {N_ENTRIES{alloc_i & alloc_link_i & check_i}};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            valid_q <= (valid_q | alloc_onehot) & ~commit_bv;
            // A linked entry waits behind its predecessor, so it is no head
            head_q  <= (head_q & ~(pop_take_i | alloc_onehot))
                     | rback_bv
                     | (alloc_onehot & {N_ENTRIES{~alloc_link_i}});
            tail_q  <= (tail_q & ~link_tail) | alloc_onehot;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (alloc_onehot[i]) begin
                req_q[i] <= alloc_req_i;
            end
            if (link_tail[i]) begin
                next_q[i] <= alloc_ptr;
            end
        end
    end

    assign valid_o        = valid_q;
    assign head_o         = head_q;
    assign tail_o         = tail_q;
    assign alloc_onehot_o = alloc_onehot;
    assign next_ptr_o     = next_q;
    assign req_o          = req_q;
    assign empty_o        = ~(|valid_q);
    assign full_o         = &valid_q;

endmodule

//--- rtl/rtab_pkg.sv
// Replay table shared sizes, request and dependency types, pop machine states
package rtab_pkg;

    // Default table depth, overridden through the top level parameter
    localparam int RTAB_ENTRIES = 8;

    // Cache-line index and request identifier widths
    localparam int NLINE_W = 26;
    localparam int ID_W = 8;

    // Entry index width, enough for the default depth
    localparam int PTR_W = 3;

    typedef logic [PTR_W-1:0] rtab_ptr_t;

    // Request held by one entry
    typedef struct packed {
        logic [NLINE_W-1:0] nline;
        logic [ID_W-1:0]    id;
    } rtab_req_t;

    // Blocking conditions of one entry
    typedef struct packed {
        // Miss pending on the same line, cleared by its refill
        logic mshr_hit;
        // Miss handler not ready, cleared by miss-ready
        logic mshr_ready;
    } rtab_deps_t;

    // Pop machine states
    typedef enum logic [1:0] {
        POP_HEAD,
        POP_NEXT,
        POP_NEXT_WAIT
    } rtab_pop_state_e;

endpackage

//--- rtl/rtab_pop_fsm.sv
// Replay table pop machine offering a list head and then walking its linked entries
module rtab_pop_fsm #(
    parameter int N_ENTRIES = 8
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    input  logic [N_ENTRIES-1:0]                 ready_i,
    input  logic [N_ENTRIES-1:0]                 gnt_i,
    input  logic [N_ENTRIES-1:0]                 tail_i,
    input  rtab_pkg::rtab_ptr_t [N_ENTRIES-1:0]  next_ptr_i,
    input  rtab_pkg::rtab_req_t [N_ENTRIES-1:0]  req_i,
    input  logic                                 pop_try_i,
    input  logic                                 pop_rback_i,

    output logic                                 advance_o,
    output logic [N_ENTRIES-1:0]                 pop_take_o,
    output logic                                 pop_try_valid_o,
    output rtab_pkg::rtab_req_t                  pop_try_req_o,
    output rtab_pkg::rtab_ptr_t                  pop_try_ptr_o
);

    rtab_pkg::rtab_pop_state_e state_q;
    rtab_pkg::rtab_pop_state_e state_d;
    logic [N_ENTRIES-1:0]      next_q;
    logic [N_ENTRIES-1:0]      next_d;
    logic [N_ENTRIES-1:0]      sel;
    logic [N_ENTRIES-1:0]      next_onehot;
    logic                      accept;
    logic                      sel_tail;

    // Heads go through the arbiter, linked entries are offered regardless of flags
    assign pop_try_valid_o = (state_q == rtab_pkg::POP_HEAD) ? (|ready_i) : 1'b1;
    assign sel             = (state_q == rtab_pkg::POP_HEAD) ? gnt_i : next_q;

    always_comb begin
        pop_try_req_o = '0;
        pop_try_ptr_o = '0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (sel[i]) begin
                pop_try_req_o = req_i[i];
                pop_try_ptr_o = rtab_pkg::rtab_ptr_t'(i);
            end
        end
    end

    // Successor of the offered entry in its list
    always_comb begin
        for (int i = 0; i < N_ENTRIES; i++) begin
            next_onehot[i] = (next_ptr_i[pop_try_ptr_o] == rtab_pkg::rtab_ptr_t'(i));
        end
    end

    assign accept     = pop_try_i & pop_try_valid_o & ~pop_rback_i;
    assign sel_tail   = |(sel & tail_i);
    assign pop_take_o = sel & {N_ENTRIES{accept}};

    always_comb begin
        state_d   = state_q;
        next_d    = next_q;
        advance_o = 1'b0;
        case (state_q)
            rtab_pkg::POP_HEAD: begin
                if (accept) begin
                    advance_o = 1'b1;
                    if (!sel_tail) begin
                        state_d = rtab_pkg::POP_NEXT;
                        next_d  = next_onehot;
                    end
                end
            end
            rtab_pkg::POP_NEXT,
            rtab_pkg::POP_NEXT_WAIT: begin
                // Rollback of the previous entry abandons the walk
                if (pop_rback_i && (state_q == rtab_pkg::POP_NEXT)) begin
                    state_d = rtab_pkg::POP_HEAD;
                end else if (accept) begin
                    if (sel_tail) begin
                        state_d = rtab_pkg::POP_HEAD;
                    end else begin
                        state_d = rtab_pkg::POP_NEXT;
                        next_d  = next_onehot;
                    end
                end else begin
                    state_d = rtab_pkg::POP_NEXT_WAIT;
                end
            end
            default: begin
                state_d = rtab_pkg::POP_HEAD;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= rtab_pkg::POP_HEAD;
            next_q  <= '0;
        end else begin
            state_q <= state_d;
            next_q  <= next_d;
        end
    end

endmodule

//--- rtl/rtab_rr_arbiter.sv
// Round-robin one-hot arbiter with a rotating priority pointer
module rtab_rr_arbiter #(
    parameter int N_REQ = 8
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic [N_REQ-1:0]    req_i,
    input  logic                advance_i,
    output logic [N_REQ-1:0]    gnt_o
);

    logic [N_REQ-1:0] prio_q;
    logic [N_REQ-1:0] mask_hi;
    logic [N_REQ-1:0] req_hi;
    logic [N_REQ-1:0] gnt_hi;
    logic [N_REQ-1:0] gnt_lo;

    // Requests at or above the pointer win first, otherwise wrap around
    assign mask_hi = ~(prio_q - 1'b1);
    assign req_hi  = req_i & mask_hi;
    assign gnt_hi  = req_hi & (~req_hi + 1'b1);
    assign gnt_lo  = req_i & (~req_i + 1'b1);
    assign gnt_o   = (|req_hi) ? gnt_hi : gnt_lo;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= {{(N_REQ-1){1'b0}}, 1'b1};
        end else if (advance_i && (|gnt_o)) begin
            prio_q <= {gnt_o[N_REQ-2:0], gnt_o[N_REQ-1]};
        end
    end

endmodule

//--- rtl/rtab_top.sv
// Replay table top level joining entry store, dependency flags, arbiter and pop machine
module rtab_top #(
    parameter int N_ENTRIES = rtab_pkg::RTAB_ENTRIES
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,

    output logic                          empty_o,
    output logic                          full_o,

    input  logic                          check_i,
    input  logic [rtab_pkg::NLINE_W-1:0]  check_nline_i,
    output logic                          check_hit_o,

    input  logic                          alloc_i,
    input  logic                          alloc_link_i,
    input  rtab_pkg::rtab_req_t           alloc_req_i,
    input  rtab_pkg::rtab_deps_t          alloc_deps_i,

    output logic                          pop_try_valid_o,
    input  logic                          pop_try_i,
    output rtab_pkg::rtab_req_t           pop_try_req_o,
    output rtab_pkg::rtab_ptr_t           pop_try_ptr_o,

    input  logic                          pop_commit_i,
    input  rtab_pkg::rtab_ptr_t           pop_commit_ptr_i,

    input  logic                          pop_rback_i,
    input  rtab_pkg::rtab_ptr_t           pop_rback_ptr_i,
    input  rtab_pkg::rtab_deps_t          pop_rback_deps_i,

    input  logic                          miss_ready_i,
    input  logic                          refill_i,
    input  logic [rtab_pkg::NLINE_W-1:0]  refill_nline_i
);

    logic [N_ENTRIES-1:0]                head;
    logic [N_ENTRIES-1:0]                tail;
    logic [N_ENTRIES-1:0]                valid;
    logic [N_ENTRIES-1:0]                alloc_onehot;
    logic [N_ENTRIES-1:0]                refill_match;
    logic [N_ENTRIES-1:0]                nodeps;
    logic [N_ENTRIES-1:0]                ready;
    logic [N_ENTRIES-1:0]                gnt;
    logic [N_ENTRIES-1:0]                pop_take;
    logic                                advance;
    rtab_pkg::rtab_ptr_t [N_ENTRIES-1:0] next_ptr;
    rtab_pkg::rtab_req_t [N_ENTRIES-1:0] req;

    // Replayable list heads
    assign ready = valid & head & nodeps;

    rtab_entry_store #(
        .N_ENTRIES (N_ENTRIES)
    ) u_store (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .alloc_i          (alloc_i),
        .alloc_link_i     (alloc_link_i),
        .alloc_req_i      (alloc_req_i),
        .check_i          (check_i),
        .check_nline_i    (check_nline_i),
        .check_hit_o      (check_hit_o),
        .pop_take_i       (pop_take),
        .pop_commit_i     (pop_commit_i),
        .pop_commit_ptr_i (pop_commit_ptr_i),
        .pop_rback_i      (pop_rback_i),
        .pop_rback_ptr_i  (pop_rback_ptr_i),
        .refill_nline_i   (refill_nline_i),
        .head_o           (head),
        .tail_o           (tail),
        .valid_o          (valid),
        .alloc_onehot_o   (alloc_onehot),
        .refill_match_o   (refill_match),
        .next_ptr_o       (next_ptr),
        .req_o            (req),
        .empty_o          (empty_o),
        .full_o           (full_o)
    );

    rtab_dep_tracker #(
        .N_ENTRIES (N_ENTRIES)
    ) u_deps (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .alloc_onehot_i   (alloc_onehot),
        .alloc_deps_i     (alloc_deps_i),
        .pop_rback_i      (pop_rback_i),
        .pop_rback_ptr_i  (pop_rback_ptr_i),
        .pop_rback_deps_i (pop_rback_deps_i),
        .refill_i         (refill_i),
        .refill_match_i   (refill_match),
        .miss_ready_i     (miss_ready_i),
        .nodeps_o         (nodeps)
    );

    rtab_rr_arbiter #(
        .N_REQ (N_ENTRIES)
    ) u_arb (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (ready),
        .advance_i (advance),
        .gnt_o     (gnt)
    );

    rtab_pop_fsm #(
        .N_ENTRIES (N_ENTRIES)
    ) u_pop (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .ready_i         (ready),
        .gnt_i           (gnt),
        .tail_i          (tail),
        .next_ptr_i      (next_ptr),
        .req_i           (req),
        .pop_try_i       (pop_try_i),
        .pop_rback_i     (pop_rback_i),
        .advance_o       (advance),
        .pop_take_o      (pop_take),
        .pop_try_valid_o (pop_try_valid_o),
        .pop_try_req_o   (pop_try_req_o),
        .pop_try_ptr_o   (pop_try_ptr_o)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build the replay table testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rtab_top.f --top-module tb_rtab \
    --Mdir obj_dir -o sim_rtab
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_rtab)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Everything OK"; then
    exit 0
fi
exit 1

//--- tb/tb_clkgen.sv
// Testbench clock and reset source with a fixed period and reset length
module tb_clkgen #(
    parameter int HALF_NS    = 10,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #HALF_NS clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2 rst_no = 1'b1;
    end

endmodule

//--- tb/tb_rtab.sv
// Replay table testbench with a table model, per-cycle compare process and watchdog
module tb_rtab;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N = rtab_pkg::RTAB_ENTRIES;
    localparam int N_TESTS = 5;

    logic clk_i;
    logic rst_ni;
    logic empty_o, full_o, check_i, check_hit_o;
    logic [rtab_pkg::NLINE_W-1:0] check_nline_i;
    logic [rtab_pkg::NLINE_W-1:0] refill_nline_i;
    logic alloc_i, alloc_link_i, pop_try_valid_o, pop_try_i;
    logic pop_commit_i, pop_rback_i, miss_ready_i, refill_i;
    rtab_pkg::rtab_req_t  alloc_req_i;
    rtab_pkg::rtab_req_t  pop_try_req_o;
    rtab_pkg::rtab_deps_t alloc_deps_i;
    rtab_pkg::rtab_deps_t pop_rback_deps_i;
    rtab_pkg::rtab_ptr_t  pop_try_ptr_o, pop_commit_ptr_i, pop_rback_ptr_i;

    // Table model
    bit [N-1:0] m_valid, m_first, m_hit, m_rdy;
    logic [rtab_pkg::NLINE_W-1:0] m_line [N];
    logic [rtab_pkg::ID_W-1:0]    m_id [N];
    int m_next [N];
    bit walking;
    int exp_next;
    bit off_v;
    int off_p;

    logic [31:0] seed = 32'hcae7_f308;
    string test_name = "reset";

    tb_clkgen #(.HALF_NS(10), .RST_CYCLES(4)) u_clk (.clk_o(clk_i), .rst_no(rst_ni));

    rtab_top #(.N_ENTRIES(N)) uut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int next_rand();
        seed = xorshift(seed);
        return int'(seed[15:0]);
    endfunction

    // Heads whose flags are clear may be replayed
    function automatic bit [N-1:0] legal_mask();
        return m_valid & m_first & ~m_hit & ~m_rdy;
    endfunction

    function automatic bit line_hit(input logic [rtab_pkg::NLINE_W-1:0] line);
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (m_valid[i] && m_line[i] == line) hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic bit has_pred(input int p);
        bit found;
        found = 1'b0;
        for (int j = 0; j < N; j++) begin
            if (m_valid[j] && m_next[j] == p) found = 1'b1;
        end
        return found;
    endfunction

    task automatic fail_plain(input string why);
        $display("%s: %s", test_name, why);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: %s expected %0h actual %0h", test_name, what, exp, act);
            $display("Something failed");
            $fatal(1, "mismatch");
        end
    endtask

    // Apply the effect of the cycle that just ended to the model
    task automatic model_update();
        int slot;
        int tl;
        int p;
        slot = -1;
        tl = -1;
        for (int i = N - 1; i >= 0; i--) begin
            if (!m_valid[i]) slot = i;
        end
        for (int i = 0; i < N; i++) begin
            if (m_valid[i] && m_line[i] == alloc_req_i.nline && m_next[i] < 0) tl = i;
        end
        if (pop_try_i && off_v && !pop_rback_i) begin
            m_first[off_p] = 1'b0;
            walking = (m_next[off_p] >= 0);
            exp_next = m_next[off_p];
        end
        if (pop_rback_i) begin
            p = int'(pop_rback_ptr_i);
            m_first[p] = 1'b1;
            m_hit[p] = m_hit[p] | pop_rback_deps_i.mshr_hit;
            m_rdy[p] = m_rdy[p] | pop_rback_deps_i.mshr_ready;
            walking = 1'b0;
        end
        if (pop_commit_i) begin
            p = int'(pop_commit_ptr_i);
            check_eq("commit in line order", 64'd0, 64'(has_pred(p)));
            m_valid[p] = 1'b0;
        end
        if (refill_i) begin
            for (int i = 0; i < N; i++) begin
                if (m_valid[i] && m_line[i] == refill_nline_i) m_hit[i] = 1'b0;
            end
        end
        if (miss_ready_i) m_rdy = '0;
        if (alloc_i && slot >= 0) begin
            m_valid[slot] = 1'b1;
            m_first[slot] = !alloc_link_i;
            m_line[slot] = alloc_req_i.nline;
            m_id[slot] = alloc_req_i.id;
            m_hit[slot] = alloc_deps_i.mshr_hit;
            m_rdy[slot] = alloc_deps_i.mshr_ready;
            m_next[slot] = -1;
            if (alloc_link_i && tl >= 0) m_next[tl] = slot;
        end
    endtask

    task automatic tick();
        @(negedge clk_i);
        off_v = pop_try_valid_o;
        off_p = int'(pop_try_ptr_o);
        @(posedge clk_i);
        #2;
        model_update();
        alloc_i = 1'b0;
        alloc_link_i = 1'b0;
        check_i = 1'b0;
        pop_try_i = 1'b0;
        pop_commit_i = 1'b0;
        pop_rback_i = 1'b0;
        refill_i = 1'b0;
        miss_ready_i = 1'b0;
    endtask

    // Compare process
    always @(negedge clk_i) begin
        bit [N-1:0] legal;
        if (rst_ni) begin
            legal = legal_mask();
            check_eq("empty", 64'(m_valid == '0), 64'(empty_o));
            check_eq("full", 64'(&m_valid), 64'(full_o));
            check_eq("check hit", 64'(check_i && line_hit(check_nline_i)), 64'(check_hit_o));
            check_eq("pop valid", 64'(walking || (legal != '0)), 64'(pop_try_valid_o));
            if (pop_try_valid_o) begin
                if (walking) begin
                    check_eq("successor", 64'(exp_next), 64'(pop_try_ptr_o));
                end else begin
                    check_eq("legal head", 64'd1, 64'(legal[pop_try_ptr_o]));
                end
                check_eq("offered id", 64'(m_id[pop_try_ptr_o]), 64'(pop_try_req_o.id));
                check_eq("offered line", 64'(m_line[pop_try_ptr_o]), 64'(pop_try_req_o.nline));
            end
        end
    end

    initial begin
        #(N_TESTS * 400 * 20);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Something failed");
        $fatal(1, "timeout");
    end

    task automatic alloc_req(input logic [25:0] line, input logic [7:0] id,
                             input bit hit, input bit rdy);
        alloc_i = 1'b1;
        alloc_req_i.nline = line;
        alloc_req_i.id = id;
        alloc_deps_i.mshr_hit = hit;
        alloc_deps_i.mshr_ready = rdy;
        check_i = 1'b1;
        check_nline_i = line;
        alloc_link_i = line_hit(line);
        tick();
    endtask

    task automatic wait_offer();
        int n;
        n = 0;
        while (!pop_try_valid_o) begin
            if (n == 60) begin
                fail_plain("no entry was offered for popping");
            end else begin
                tick();
                n++;
            end
        end
    endtask

    task automatic expect_no_offer(input int cycles);
        repeat (cycles) begin
            check_eq("held back", 64'd0, 64'(pop_try_valid_o));
            tick();
        end
    endtask

    task automatic pop_commit_one(output logic [7:0] id);
        rtab_pkg::rtab_ptr_t p;
        wait_offer();
        p = pop_try_ptr_o;
        id = pop_try_req_o.id;
        pop_try_i = 1'b1;
        tick();
        pop_commit_i = 1'b1;
        pop_commit_ptr_i = p;
        tick();
    endtask

    task automatic refill_line(input logic [25:0] line);
        refill_i = 1'b1;
        refill_nline_i = line;
        tick();
    endtask

    // Accept a head and walk its list, randomly committing or rolling back
    task automatic pop_walk();
        rtab_pkg::rtab_ptr_t p;
        bit more;
        repeat (next_rand() % 3) tick();
        p = pop_try_ptr_o;
        pop_try_i = 1'b1;
        tick();
        more = 1'b1;
        while (more) begin
            if (next_rand() % 4 == 0) begin
                pop_rback_i = 1'b1;
                pop_rback_ptr_i = p;
                pop_rback_deps_i.mshr_hit = (next_rand() % 3 == 0);
                pop_rback_deps_i.mshr_ready = (next_rand() % 5 == 0);
                tick();
                more = 1'b0;
            end else begin
                pop_commit_i = 1'b1;
                pop_commit_ptr_i = p;
                if (walking) begin
                    if (next_rand() % 2 == 1) begin
                        tick();
                        repeat (next_rand() % 2) tick();
                    end
                    p = pop_try_ptr_o;
                    pop_try_i = 1'b1;
                    tick();
                end else begin
                    tick();
                    more = 1'b0;
                end
            end
        end
    endtask

    initial begin
        logic [25:0] lines [N];
        logic [25:0] base;
        logic [7:0]  id;
        int r;
        {check_i, alloc_i, alloc_link_i, pop_try_i, pop_commit_i} = '0;
        {pop_rback_i, miss_ready_i, refill_i} = '0;
        check_nline_i = '0;
        refill_nline_i = '0;
        alloc_req_i = '0;
        alloc_deps_i = '0;
        pop_rback_deps_i = '0;
        pop_commit_ptr_i = '0;
        pop_rback_ptr_i = '0;
        m_valid = '0;
        m_first = '0;
        m_hit = '0;
        m_rdy = '0;
        walking = 1'b0;
        exp_next = -1;
        for (int i = 0; i < N; i++) m_next[i] = -1;
        @(posedge rst_ni);

        test_name = "fill_and_check";
        check_eq("empty after reset", 64'd1, 64'(empty_o));
        check_eq("no offer after reset", 64'd0, 64'(pop_try_valid_o));
        for (int i = 0; i < N; i++) begin
            lines[i] = {26'(next_rand()) & 26'h3ff_fff8} | 26'(i);
            alloc_req(lines[i], 8'(next_rand()), 1'b0, 1'b0);
        end
        check_eq("full", 64'd1, 64'(full_o));
        for (int i = 0; i < 2 * N; i++) begin
            check_i = 1'b1;
            check_nline_i = (i < N) ? lines[i] : 26'(next_rand());
            tick();
        end
        repeat (N) pop_commit_one(id);

        test_name = "linked_order";
        base = 26'(next_rand());
        for (int k = 1; k <= 3; k++) alloc_req(base, 8'(k), 1'b0, 1'b0);
        wait_offer();
        check_eq("first id", 64'd1, 64'(pop_try_req_o.id));
        for (int k = 1; k <= 3; k++) begin
            if (k > 1) begin
                pop_commit_i = 1'b1;
                pop_commit_ptr_i = rtab_pkg::rtab_ptr_t'(off_p);
            end
            check_eq("offered in order", 64'(k), 64'(pop_try_req_o.id));
            check_eq("offer without gap", 64'd1, 64'(pop_try_valid_o));
            pop_try_i = 1'b1;
            tick();
        end
        pop_commit_i = 1'b1;
        pop_commit_ptr_i = rtab_pkg::rtab_ptr_t'(off_p);
        tick();
        check_eq("empty after commits", 64'd1, 64'(empty_o));

        test_name = "dependency_release";
        alloc_req(base, 8'h21, 1'b1, 1'b0);
        expect_no_offer(3);
        refill_line(base ^ 26'h1);
        expect_no_offer(2);
        refill_line(base);
        pop_commit_one(id);
        check_eq("refilled id", 64'h21, 64'(id));
        alloc_req(base, 8'h22, 1'b0, 1'b1);
        expect_no_offer(3);
        miss_ready_i = 1'b1;
        tick();
        pop_commit_one(id);
        check_eq("miss ready id", 64'h22, 64'(id));

        test_name = "rollback";
        alloc_req(base, 8'h31, 1'b0, 1'b0);
        wait_offer();
        pop_try_i = 1'b1;
        tick();
        pop_rback_i = 1'b1;
        pop_rback_ptr_i = rtab_pkg::rtab_ptr_t'(off_p);
        pop_rback_deps_i = '{mshr_hit: 1'b1, mshr_ready: 1'b0};
        tick();
        expect_no_offer(3);
        refill_line(base);
        wait_offer();
        check_eq("same id after refill", 64'h31, 64'(pop_try_req_o.id));
        pop_try_i = 1'b1;
        tick();
        pop_rback_i = 1'b1;
        pop_rback_ptr_i = rtab_pkg::rtab_ptr_t'(off_p);
        pop_rback_deps_i = '0;
        tick();
        pop_commit_one(id);
        check_eq("same id after rollback", 64'h31, 64'(id));

        test_name = "random_mix";
        for (int it = 0; it < 150; it++) begin
            r = next_rand() % 8;
            if (r < 3 && !full_o) begin
                alloc_req(base + 26'(next_rand() % 4), 8'(next_rand()),
                          next_rand() % 4 == 0, next_rand() % 4 == 0);
            end else if (r == 3) begin
                refill_line(base + 26'(next_rand() % 4));
            end else if (r == 4) begin
                miss_ready_i = 1'b1;
                tick();
            end else if (pop_try_valid_o) begin
                pop_walk();
            end else begin
                tick();
            end
        end

        $display("Everything OK");
        $finish;
    end

endmodule
